// ==== verilog/rv_isa_pkg.sv ====
package rv_isa_pkg;

  // datapath width
  localparam int XLEN = 32;
  typedef logic [XLEN-1:0] word_t;

  localparam int NUM_REGS = 32;
  typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;

  // instruction ROM, word addressed
  localparam int ROM_WORDS = 256;
  typedef logic [$clog2(ROM_WORDS)-1:0] rom_addr_t;

  typedef logic [6:0] opcode_t;

  // opcodes kept by this core
  localparam opcode_t OP_LUI     = 7'b0110111;
  localparam opcode_t OP_REG_IMM = 7'b0010011;
  localparam opcode_t OP_REG_REG = 7'b0110011;
  localparam opcode_t OP_BRANCH  = 7'b1100011;
  localparam opcode_t OP_ENVIRON = 7'b1110011;

  // funct7, alternate form selects sub and sra
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  localparam word_t ECALL_INSN = 32'h0000_0073;
  localparam word_t PC_STEP    = 32'd4;

endpackage

// ==== verilog/pipe_pkg.sv ====
package pipe_pkg;

  // what occupies a slot as it moves down the pipe
  typedef enum logic [2:0] {
    INVALID      = 3'd0,
    RESET        = 3'd1,
    NO_STALL     = 3'd2,
    TAKEN_BRANCH = 3'd4
  } cycle_status_e;

  // fetch to decode
  typedef struct packed {
    rv_isa_pkg::word_t pc;
    rv_isa_pkg::word_t insn;
  } decode_t;

  // decode to execute, register file data before bypass
  typedef struct packed {
    rv_isa_pkg::word_t pc;
    rv_isa_pkg::word_t insn;
    rv_isa_pkg::word_t rs1_data;
    rv_isa_pkg::word_t rs2_data;
  } execute_t;

  // execute to memory and memory to writeback
  typedef struct packed {
    rv_isa_pkg::word_t    pc;
    rv_isa_pkg::word_t    insn;
    rv_isa_pkg::reg_idx_t rd;
    logic                 rd_we;
    logic                 is_ecall;
    rv_isa_pkg::word_t    result;
  } result_t;

endpackage

// ==== verilog/stage_reg.sv ====
`timescale 1ns/1ps

module stage_reg #(
  parameter type payload_t = logic
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    flush_i,
  input  payload_t                data_i,
  input  pipe_pkg::cycle_status_e status_i,
  output payload_t                data_o,
  output pipe_pkg::cycle_status_e status_o
);

  always_ff @(posedge clk) begin
    if (rst) begin
      data_o   <= '0;
      status_o <= pipe_pkg::RESET;
    end else if (flush_i) begin
      // squashed slot keeps no payload
      data_o   <= '0;
      status_o <= pipe_pkg::TAKEN_BRANCH;
    end else begin
      data_o   <= data_i;
      status_o <= status_i;
    end
  end

endmodule

// ==== verilog/insn_rom.sv ====
`timescale 1ns/1ps

module insn_rom (
  input  logic                  clk,
  input  logic                  rom_we_i,
  input  rv_isa_pkg::rom_addr_t rom_addr_i,
  input  rv_isa_pkg::word_t     rom_data_i,
  input  rv_isa_pkg::word_t     pc_i,
  output rv_isa_pkg::word_t     insn_o
);

  localparam int AddrW = $bits(rv_isa_pkg::rom_addr_t);

  rv_isa_pkg::word_t     mem [rv_isa_pkg::ROM_WORDS];
  rv_isa_pkg::rom_addr_t rd_addr;

  // word index, upper pc bits wrap
  assign rd_addr = pc_i[AddrW+1:2];

  // loaded one word per cycle while the core sits in reset
  always_ff @(posedge clk) begin
    if (rom_we_i) begin
      mem[rom_addr_i] <= rom_data_i;
    end
  end

  assign insn_o = mem[rd_addr];

endmodule

// ==== verilog/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 we_i,
  input  rv_isa_pkg::reg_idx_t rd_i,
  input  rv_isa_pkg::word_t    rd_data_i,
  input  rv_isa_pkg::reg_idx_t rs1_i,
  input  rv_isa_pkg::reg_idx_t rs2_i,
  output rv_isa_pkg::word_t    rs1_data_o,
  output rv_isa_pkg::word_t    rs2_data_o
);

  rv_isa_pkg::word_t regs [rv_isa_pkg::NUM_REGS];
  logic              wr_live;

  // x0 is never written, so it stays at its reset value
  assign wr_live = we_i && (rd_i != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < rv_isa_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_live) begin
      regs[rd_i] <= rd_data_i;
    end
  end

  // write-through, decode sees the value retiring this cycle
  assign rs1_data_o = (wr_live && rs1_i == rd_i) ? rd_data_i : regs[rs1_i];
  assign rs2_data_o = (wr_live && rs2_i == rd_i) ? rd_data_i : regs[rs2_i];

endmodule

// ==== verilog/operand_bypass.sv ====
`timescale 1ns/1ps

module operand_bypass (
  input  rv_isa_pkg::word_t       ex_insn_i,
  input  rv_isa_pkg::word_t       ex_rs1_data_i,
  input  rv_isa_pkg::word_t       ex_rs2_data_i,
  input  pipe_pkg::result_t       mem_slot_i,
  input  pipe_pkg::result_t       wb_slot_i,
  input  pipe_pkg::cycle_status_e mem_status_i,
  input  pipe_pkg::cycle_status_e wb_status_i,
  output rv_isa_pkg::word_t       op_a_o,
  output rv_isa_pkg::word_t       op_b_o
);

  rv_isa_pkg::reg_idx_t rs1;
  rv_isa_pkg::reg_idx_t rs2;
  logic                 mem_fwd_ok;
  logic                 wb_fwd_ok;

  assign rs1 = ex_insn_i[19:15];
  assign rs2 = ex_insn_i[24:20];

  // only live slots that really write a register may forward
  assign mem_fwd_ok = (mem_status_i == pipe_pkg::NO_STALL) && mem_slot_i.rd_we &&
                      (mem_slot_i.rd != '0);
  assign wb_fwd_ok  = (wb_status_i == pipe_pkg::NO_STALL) && wb_slot_i.rd_we &&
                      (wb_slot_i.rd != '0);

  // younger producer in memory wins over writeback
  function automatic rv_isa_pkg::word_t pick(rv_isa_pkg::reg_idx_t src,
                                             rv_isa_pkg::word_t rf_data);
    if (mem_fwd_ok && mem_slot_i.rd == src) begin
      return mem_slot_i.result;
    end else if (wb_fwd_ok && wb_slot_i.rd == src) begin
      return wb_slot_i.result;
    end
    return rf_data;
  endfunction

  assign op_a_o = pick(rs1, ex_rs1_data_i);
  assign op_b_o = pick(rs2, ex_rs2_data_i);

endmodule

// ==== verilog/exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit (
  input  pipe_pkg::execute_t      ex_slot_i,
  input  pipe_pkg::cycle_status_e ex_status_i,
  input  rv_isa_pkg::word_t       op_a_i,
  input  rv_isa_pkg::word_t       op_b_i,
  output pipe_pkg::result_t       result_o,
  output pipe_pkg::cycle_status_e status_o,
  output logic                    branch_taken_o,
  output rv_isa_pkg::word_t       branch_target_o
);

  rv_isa_pkg::opcode_t opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic                is_reg_reg;
  logic                alt;
  rv_isa_pkg::word_t   imm_i;
  rv_isa_pkg::word_t   imm_b;
  rv_isa_pkg::word_t   imm_u;
  rv_isa_pkg::word_t   alu_b;
  logic [4:0]          shamt;
  rv_isa_pkg::word_t   alu_out;
  logic                writes_rd;
  logic                cond_true;
  logic                illegal;
  logic                live;

  assign opcode     = ex_slot_i.insn[6:0];
  assign funct3     = ex_slot_i.insn[14:12];
  assign funct7     = ex_slot_i.insn[31:25];
  assign is_reg_reg = (opcode == rv_isa_pkg::OP_REG_REG);
  assign alt        = (funct7 == rv_isa_pkg::F7_ALT);
  assign live       = (ex_status_i == pipe_pkg::NO_STALL);

  // immediate forms
  assign imm_i = {{20{ex_slot_i.insn[31]}}, ex_slot_i.insn[31:20]};
  assign imm_b = {{20{ex_slot_i.insn[31]}}, ex_slot_i.insn[7], ex_slot_i.insn[30:25],
                  ex_slot_i.insn[11:8], 1'b0};
  assign imm_u = {ex_slot_i.insn[31:12], 12'b0};

  // reg-imm ops take the I immediate as second operand
  assign alu_b = is_reg_reg ? op_b_i : imm_i;
  assign shamt = is_reg_reg ? op_b_i[4:0] : ex_slot_i.insn[24:20];

  always_comb begin
    case (funct3)
      3'b000: alu_out = (is_reg_reg && alt) ? op_a_i - alu_b : op_a_i + alu_b;
      3'b001: alu_out = op_a_i << shamt;
      3'b010: alu_out = {31'b0, $signed(op_a_i) < $signed(alu_b)};
      3'b011: alu_out = {31'b0, op_a_i < alu_b};
      3'b100: alu_out = op_a_i ^ alu_b;
      3'b101: begin
        // kept apart so the arithmetic shift stays signed
        if (alt) begin
          alu_out = $signed(op_a_i) >>> shamt;
        end else begin
          alu_out = op_a_i >> shamt;
        end
      end
      3'b110: alu_out = op_a_i | alu_b;
      default: alu_out = op_a_i & alu_b;
    endcase
  end

  // class decode, legality and branch compare
  always_comb begin
    writes_rd = 1'b0;
    cond_true = 1'b0;
    illegal   = 1'b0;
    case (opcode)
      rv_isa_pkg::OP_LUI: writes_rd = 1'b1;
      rv_isa_pkg::OP_REG_IMM: begin
        writes_rd = 1'b1;
        if (funct3 == 3'b001) begin
          illegal = (funct7 != rv_isa_pkg::F7_BASE);
        end else if (funct3 == 3'b101) begin
          illegal = (funct7 != rv_isa_pkg::F7_BASE) && !alt;
        end
      end
      rv_isa_pkg::OP_REG_REG: begin
        writes_rd = 1'b1;
        illegal   = (funct7 != rv_isa_pkg::F7_BASE) &&
                    !(alt && (funct3 == 3'b000 || funct3 == 3'b101));
      end
      rv_isa_pkg::OP_BRANCH: begin
        case (funct3)
          3'b000: cond_true = (op_a_i == op_b_i);
          3'b001: cond_true = (op_a_i != op_b_i);
          3'b100: cond_true = ($signed(op_a_i) < $signed(op_b_i));
          3'b101: cond_true = ($signed(op_a_i) >= $signed(op_b_i));
          3'b110: cond_true = (op_a_i < op_b_i);
          3'b111: cond_true = (op_a_i >= op_b_i);
          default: illegal = 1'b1;
        endcase
      end
      rv_isa_pkg::OP_ENVIRON: illegal = (ex_slot_i.insn != rv_isa_pkg::ECALL_INSN);
      default: illegal = 1'b1;
    endcase
  end

  always_comb begin
    result_o.pc       = ex_slot_i.pc;
    result_o.insn     = ex_slot_i.insn;
    result_o.rd       = ex_slot_i.insn[11:7];
    // writes to x0 are dropped here
    result_o.rd_we    = live && writes_rd && !illegal && (ex_slot_i.insn[11:7] != '0);
    result_o.is_ecall = live && (ex_slot_i.insn == rv_isa_pkg::ECALL_INSN);
    if (!live) begin
      result_o.result = '0;
    end else if (opcode == rv_isa_pkg::OP_LUI) begin
      result_o.result = imm_u;
    end else begin
      result_o.result = alu_out;
    end
  end

  assign status_o        = (live && illegal) ? pipe_pkg::INVALID : ex_status_i;
  assign branch_taken_o  = live && cond_true;
  assign branch_target_o = branch_taken_o ? ex_slot_i.pc + imm_b : '0;

endmodule

// ==== verilog/pipe_ctrl.sv ====
`timescale 1ns/1ps

module pipe_ctrl (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    branch_taken_i,
  input  rv_isa_pkg::word_t       branch_target_i,
  input  pipe_pkg::result_t       wb_slot_i,
  input  pipe_pkg::cycle_status_e wb_status_i,
  output rv_isa_pkg::word_t       pc_o,
  output logic                    flush_o,
  output logic                    halt_o,
  output logic                    retire_valid_o,
  output logic                    rf_we_o
);

  typedef enum logic {
    RUN,
    HALTED
  } state_e;

  state_e state;

  // commit gating at writeback
  assign retire_valid_o = (state == RUN) && (wb_status_i == pipe_pkg::NO_STALL);
  assign rf_we_o        = retire_valid_o && wb_slot_i.rd_we;
  // rises with the retiring ECALL, held by the state afterwards
  assign halt_o         = (state == HALTED) || (retire_valid_o && wb_slot_i.is_ecall);

  // taken branch squashes decode and execute
  assign flush_o = branch_taken_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= RUN;
    end else begin
      case (state)
        RUN: begin
          if (halt_o) begin
            state <= HALTED;
          end
        end
        default: state <= HALTED;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_o <= '0;
    end else if (state == RUN) begin
      if (branch_taken_i) begin
        pc_o <= branch_target_i;
      end else begin
        pc_o <= pc_o + rv_isa_pkg::PC_STEP;
      end
    end
  end

endmodule

// ==== verilog/rv_pipe_top.sv ====
`timescale 1ns/1ps

module rv_pipe_top (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    rom_we_i,
  input  rv_isa_pkg::rom_addr_t   rom_addr_i,
  input  rv_isa_pkg::word_t       rom_data_i,
  output logic                    halt_o,
  output logic                    retire_valid_o,
  output rv_isa_pkg::word_t       retire_pc_o,
  output rv_isa_pkg::word_t       retire_insn_o,
  output pipe_pkg::cycle_status_e retire_status_o,
  output logic                    rf_we_o,
  output rv_isa_pkg::reg_idx_t    rf_rd_o,
  output rv_isa_pkg::word_t       rf_data_o
);

  rv_isa_pkg::word_t       pc;
  rv_isa_pkg::word_t       fetch_insn;
  logic                    flush;
  logic                    branch_taken;
  rv_isa_pkg::word_t       branch_target;
  pipe_pkg::decode_t       fetch_slot;
  pipe_pkg::decode_t       dec_slot;
  pipe_pkg::execute_t      dec_out;
  pipe_pkg::execute_t      ex_slot;
  pipe_pkg::result_t       exu_result;
  pipe_pkg::result_t       mem_slot;
  pipe_pkg::result_t       wb_slot;
  pipe_pkg::cycle_status_e dec_status;
  pipe_pkg::cycle_status_e ex_status;
  pipe_pkg::cycle_status_e exu_status;
  pipe_pkg::cycle_status_e mem_status;
  pipe_pkg::cycle_status_e wb_status;
  rv_isa_pkg::word_t       rs1_data;
  rv_isa_pkg::word_t       rs2_data;
  rv_isa_pkg::word_t       op_a;
  rv_isa_pkg::word_t       op_b;

  // fetch
  insn_rom i_insn_rom (
    .clk        (clk),
    .rom_we_i   (rom_we_i),
    .rom_addr_i (rom_addr_i),
    .rom_data_i (rom_data_i),
    .pc_i       (pc),
    .insn_o     (fetch_insn)
  );

  assign fetch_slot = '{pc: pc, insn: fetch_insn};

  stage_reg #(.payload_t(pipe_pkg::decode_t)) i_dec_stage (
    .clk      (clk),
    .rst      (rst),
    .flush_i  (flush),
    .data_i   (fetch_slot),
    .status_i (pipe_pkg::NO_STALL),
    .data_o   (dec_slot),
    .status_o (dec_status)
  );

  // decode, register read with write-through from writeback
  reg_file i_reg_file (
    .clk        (clk),
    .rst        (rst),
    .we_i       (rf_we_o),
    .rd_i       (wb_slot.rd),
    .rd_data_i  (wb_slot.result),
    .rs1_i      (dec_slot.insn[19:15]),
    .rs2_i      (dec_slot.insn[24:20]),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  assign dec_out = '{pc: dec_slot.pc, insn: dec_slot.insn,
                     rs1_data: rs1_data, rs2_data: rs2_data};

  stage_reg #(.payload_t(pipe_pkg::execute_t)) i_ex_stage (
    .clk      (clk),
    .rst      (rst),
    .flush_i  (flush),
    .data_i   (dec_out),
    .status_i (dec_status),
    .data_o   (ex_slot),
    .status_o (ex_status)
  );

  // execute
  operand_bypass i_operand_bypass (
    .ex_insn_i     (ex_slot.insn),
    .ex_rs1_data_i (ex_slot.rs1_data),
    .ex_rs2_data_i (ex_slot.rs2_data),
    .mem_slot_i    (mem_slot),
    .wb_slot_i     (wb_slot),
    .mem_status_i  (mem_status),
    .wb_status_i   (wb_status),
    .op_a_o        (op_a),
    .op_b_o        (op_b)
  );

  exec_unit i_exec_unit (
    .ex_slot_i       (ex_slot),
    .ex_status_i     (ex_status),
    .op_a_i          (op_a),
    .op_b_i          (op_b),
    .result_o        (exu_result),
    .status_o        (exu_status),
    .branch_taken_o  (branch_taken),
    .branch_target_o (branch_target)
  );

  // memory stage is a plain register, no data memory
  stage_reg #(.payload_t(pipe_pkg::result_t)) i_mem_stage (
    .clk      (clk),
    .rst      (rst),
    .flush_i  (1'b0),
    .data_i   (exu_result),
    .status_i (exu_status),
    .data_o   (mem_slot),
    .status_o (mem_status)
  );

  stage_reg #(.payload_t(pipe_pkg::result_t)) i_wb_stage (
    .clk      (clk),
    .rst      (rst),
    .flush_i  (1'b0),
    .data_i   (mem_slot),
    .status_i (mem_status),
    .data_o   (wb_slot),
    .status_o (wb_status)
  );

  pipe_ctrl i_pipe_ctrl (
    .clk             (clk),
    .rst             (rst),
    .branch_taken_i  (branch_taken),
    .branch_target_i (branch_target),
    .wb_slot_i       (wb_slot),
    .wb_status_i     (wb_status),
    .pc_o            (pc),
    .flush_o         (flush),
    .halt_o          (halt_o),
    .retire_valid_o  (retire_valid_o),
    .rf_we_o         (rf_we_o)
  );

  // writeback trace
  assign retire_pc_o     = wb_slot.pc;
  assign retire_insn_o   = wb_slot.insn;
  assign retire_status_o = wb_status;
  assign rf_rd_o         = wb_slot.rd;
  assign rf_data_o       = wb_slot.result;

endmodule

// ==== include/rv_ref_model.svh ====
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

// instruction-level model, one step per slot that leaves writeback
rv_isa_pkg::word_t    prog[$];
rv_isa_pkg::word_t    ref_regs[rv_isa_pkg::NUM_REGS];
rv_isa_pkg::word_t    ref_pc;
rv_isa_pkg::word_t    ref_insn;
rv_isa_pkg::reg_idx_t ref_rd;
rv_isa_pkg::word_t    ref_data;
bit                   ref_we;
bit                   ref_illegal;
bit                   ref_taken;
bit                   ref_halted;
int unsigned          ref_retired;

function automatic void clear_model();
  foreach (ref_regs[i]) begin
    ref_regs[i] = '0;
  end
  ref_pc      = '0;
  ref_halted  = 1'b0;
  ref_retired = 0;
endfunction

// forward branches and ALU ops on x0..x7, some illegal words, ECALL last
function automatic void gen_program(int unsigned len);
  rv_isa_pkg::word_t w;
  logic [12:0]       off;
  int unsigned       kind;
  int unsigned       reach;
  prog.delete();
  for (int unsigned i = 0; i + 1 < len; i++) begin
    kind = $urandom_range(0, 9);
    w = $urandom;
    w[24:15] = {2'b0, w[22:20], 2'b0, w[17:15]};
    w[11:7] = {2'b0, w[9:7]};
    if (kind == 0) begin
      // custom-0 opcode, never decoded by the core
      w[6:0] = 7'b0001011;
    end else if (kind < 3) begin
      reach = len - 1 - i;
      off = 13'($urandom_range(1, (reach < 4) ? reach : 4) * 4);
      if (w[14:13] == 2'b01) begin
        w[14] = 1'b1;
      end
      w = {off[12], off[10:5], w[24:12], off[4:1], off[11], rv_isa_pkg::OP_BRANCH};
    end else if (kind < 6) begin
      w[6:0] = rv_isa_pkg::OP_REG_IMM;
      if (w[14:12] == 3'b001) begin
        w[31:25] = rv_isa_pkg::F7_BASE;
      end else if (w[14:12] == 3'b101) begin
        w[31:25] = w[30] ? rv_isa_pkg::F7_ALT : rv_isa_pkg::F7_BASE;
      end
    end else if (kind < 9) begin
      w[6:0] = rv_isa_pkg::OP_REG_REG;
      w[31:25] = (w[30] && (w[14:12] == 3'b000 || w[14:12] == 3'b101)) ?
                 rv_isa_pkg::F7_ALT : rv_isa_pkg::F7_BASE;
    end else begin
      w[6:0] = rv_isa_pkg::OP_LUI;
    end
    prog.push_back(w);
  end
  prog.push_back(rv_isa_pkg::ECALL_INSN);
endfunction

function automatic void step_model();
  rv_isa_pkg::word_t a;
  rv_isa_pkg::word_t b;
  rv_isa_pkg::word_t rb;
  logic [2:0]        f3;
  bit                alt;
  ref_insn = prog[ref_pc >> 2];
  a = ref_regs[ref_insn[19:15]];
  rb = ref_regs[ref_insn[24:20]];
  b = (ref_insn[6:0] == rv_isa_pkg::OP_REG_REG) ? rb :
      {{20{ref_insn[31]}}, ref_insn[31:20]};
  f3 = ref_insn[14:12];
  alt = (ref_insn[31:25] == rv_isa_pkg::F7_ALT);
  ref_rd = ref_insn[11:7];
  ref_data = '0;
  ref_we = 1'b0;
  ref_taken = 1'b0;
  ref_illegal = 1'b0;
  case (ref_insn[6:0])
    rv_isa_pkg::OP_LUI: begin
      ref_data = {ref_insn[31:12], 12'b0};
      ref_we = 1'b1;
    end
    rv_isa_pkg::OP_REG_IMM, rv_isa_pkg::OP_REG_REG: begin
      ref_we = 1'b1;
      case (f3)
        3'b000: ref_data = (ref_insn[6:0] == rv_isa_pkg::OP_REG_REG && alt) ? a - b : a + b;
        3'b001: ref_data = a << b[4:0];
        3'b010: ref_data = {31'b0, $signed(a) < $signed(b)};
        3'b011: ref_data = {31'b0, a < b};
        3'b100: ref_data = a ^ b;
        3'b101: begin
          if (alt) begin
            ref_data = $signed(a) >>> b[4:0];
          end else begin
            ref_data = a >> b[4:0];
          end
        end
        3'b110: ref_data = a | b;
        default: ref_data = a & b;
      endcase
    end
    rv_isa_pkg::OP_BRANCH: begin
      case (f3)
        3'b000: ref_taken = (a == rb);
        3'b001: ref_taken = (a != rb);
        3'b100: ref_taken = ($signed(a) < $signed(rb));
        3'b101: ref_taken = ($signed(a) >= $signed(rb));
        3'b110: ref_taken = (a < rb);
        default: ref_taken = (a >= rb);
      endcase
    end
    // the generator emits no other environment word
    rv_isa_pkg::OP_ENVIRON: ref_halted = 1'b1;
    default: ref_illegal = 1'b1;
  endcase
  ref_we = ref_we && (ref_rd != '0);
  if (ref_we) begin
    ref_regs[ref_rd] = ref_data;
  end
  if (!ref_illegal) begin
    ref_retired++;
  end
  if (ref_taken) begin
    ref_pc = ref_pc + {{20{ref_insn[31]}}, ref_insn[7], ref_insn[30:25], ref_insn[11:8], 1'b0};
  end else begin
    ref_pc = ref_pc + rv_isa_pkg::PC_STEP;
  end
endfunction

`endif

// ==== verification/tb_rv_pipe.sv ====
`timescale 1ns/1ps

module tb_rv_pipe;

  localparam int unsigned SEED           = 32'h24aab516;
  localparam int          PROG_LEN       = 200;
  localparam int          RESET_CYCLES   = 8;
  localparam int          HOLD_CYCLES    = 8;
  localparam int          TIMEOUT_CYCLES = PROG_LEN * 4 + 50;

  logic                    clk;
  logic                    rst;
  logic                    rom_we;
  rv_isa_pkg::rom_addr_t   rom_addr;
  rv_isa_pkg::word_t       rom_data;
  logic                    halt;
  logic                    retire_valid;
  rv_isa_pkg::word_t       retire_pc;
  rv_isa_pkg::word_t       retire_insn;
  pipe_pkg::cycle_status_e retire_status;
  logic                    rf_we;
  rv_isa_pkg::reg_idx_t    rf_rd;
  rv_isa_pkg::word_t       rf_data;

  int unsigned retire_count;
  int unsigned hold_count;
  int          squash_left;
  bit          started;
  bit          halted_seen;

`include "rv_ref_model.svh"

  rv_pipe_top i_rv_pipe_top (
    .clk             (clk),
    .rst             (rst),
    .rom_we_i        (rom_we),
    .rom_addr_i      (rom_addr),
    .rom_data_i      (rom_data),
    .halt_o          (halt),
    .retire_valid_o  (retire_valid),
    .retire_pc_o     (retire_pc),
    .retire_insn_o   (retire_insn),
    .retire_status_o (retire_status),
    .rf_we_o         (rf_we),
    .rf_rd_o         (rf_rd),
    .rf_data_o       (rf_data)
  );

  always #5 clk = ~clk;

  task automatic abort_run();
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input rv_isa_pkg::word_t got,
                            input rv_isa_pkg::word_t exp);
    assert (got === exp) else begin
      $display("ERR %s: got 0x%08h, expected 0x%08h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_true(input bit cond, input string what);
    assert (cond) else begin
      $display("%s", what);
      abort_run();
    end
  endtask

  // custom-0 filler that spreads the whole address over the word
  function automatic rv_isa_pkg::word_t fill_word(input rv_isa_pkg::rom_addr_t a);
    return {a, ~a, a, 1'b0, 7'b0001011};
  endfunction

  // one call per writeback slot once reset is over
  task automatic check_slot();
    rv_isa_pkg::word_t exp_pc;
    if (halted_seen) begin
      check_true(halt === 1'b1, "halt_o dropped after the ECALL retired");
      check_true(retire_valid === 1'b0, "retire_valid_o rose while the core was halted");
      check_true(rf_we === 1'b0, "rf_we_o rose while the core was halted");
      hold_count++;
      if (hold_count == HOLD_CYCLES) begin
        check_word("retire count", retire_count, ref_retired);
        $display("TESTBENCH PASSED");
        $finish;
      end
    end else begin
      check_true(retire_valid === (retire_status == pipe_pkg::NO_STALL),
                 "retire_valid_o does not match the writeback slot status");
      if (rf_rd == '0) begin
        check_true(rf_we === 1'b0, "rf_we_o is high for a write to x0");
      end
      case (retire_status)
        pipe_pkg::RESET: begin
          check_true(!started, "a RESET slot reached writeback after the first instruction");
        end
        pipe_pkg::TAKEN_BRANCH: begin
          check_true(squash_left > 0, "a squashed slot appeared without a taken branch ahead");
          squash_left--;
          check_true(rf_we === 1'b0, "rf_we_o is high for a squashed slot");
        end
        pipe_pkg::NO_STALL, pipe_pkg::INVALID: begin
          check_true(squash_left == 0, "fewer than two squashed slots after a taken branch");
          started = 1'b1;
          exp_pc  = ref_pc;
          step_model();
          check_word("retire_pc_o", retire_pc, exp_pc);
          check_word("retire_insn_o", retire_insn, ref_insn);
          check_word("retire_status_o", 32'(retire_status),
                     ref_illegal ? 32'(pipe_pkg::INVALID) : 32'(pipe_pkg::NO_STALL));
          check_word("rf_we_o", 32'(rf_we), 32'(ref_we));
          if (ref_we) begin
            check_word("rf_rd_o", 32'(rf_rd), 32'(ref_rd));
            check_word("rf_data_o", rf_data, ref_data);
          end
          check_word("halt_o", 32'(halt), 32'(ref_halted));
          if (retire_valid) begin
            retire_count++;
          end
          if (ref_taken) begin
            squash_left = 2;
          end
          halted_seen = ref_halted;
        end
        default: check_true(1'b0, "writeback slot status is not a known value");
      endcase
    end
  endtask

  // program generation and ROM load under reset
  initial begin
    clk          = 1'b0;
    rst          = 1'b1;
    rom_we       = 1'b0;
    rom_addr     = '0;
    rom_data     = '0;
    retire_count = 0;
    hold_count   = 0;
    squash_left  = 0;
    started      = 1'b0;
    halted_seen  = 1'b0;
    void'($urandom(SEED));
    clear_model();
    gen_program(PROG_LEN);
    for (int a = 0; a < rv_isa_pkg::ROM_WORDS; a++) begin
      @(posedge clk);
      rom_we   <= 1'b1;
      rom_addr <= rv_isa_pkg::rom_addr_t'(a);
      if (a < prog.size()) begin
        rom_data <= prog[a];
      end else begin
        rom_data <= fill_word(rv_isa_pkg::rom_addr_t'(a));
      end
    end
    @(posedge clk);
    rom_we <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
  end

  // writeback outputs are stable at the falling edge
  always @(negedge clk) begin
    if (rst === 1'b0) begin
      check_slot();
    end
  end

  // the program must reach its ECALL in time
  initial begin
    @(negedge rst);
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("timeout: the core did not halt within %0d cycles after reset", TIMEOUT_CYCLES);
    abort_run();
  end

endmodule

// ==== sources.f ====
+incdir+include
verilog/rv_isa_pkg.sv
verilog/pipe_pkg.sv
verilog/stage_reg.sv
verilog/insn_rom.sv
verilog/reg_file.sv
verilog/operand_bypass.sv
verilog/exec_unit.sv
verilog/pipe_ctrl.sv
verilog/rv_pipe_top.sv
verification/tb_rv_pipe.sv

// ==== Makefile ====
TOP := tb_rv_pipe

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing -j 0 --top-module $(TOP) -f sources.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
